// ==== hdl/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input  mipsDecodePkg::opcode_t opcode,
    input  mipsDecodePkg::funct_t funct,
    input  logic [mipsDecodePkg::regAddrWidth-1:0] rt,
    output mipsDecodePkg::ctrl_t ctrl,
    output mipsDecodePkg::regDst_t regDst
);

    always_comb
    begin
        // Everything off unless an opcode turns it on
        ctrl = '0;
        regDst = mipsDecodePkg::RT;

        case (opcode)
            mipsDecodePkg::RTYPE:
            begin
                regDst = mipsDecodePkg::RD;
                ctrl.regWrite = mipsDecodePkg::FULL;
                case (funct)
                    mipsDecodePkg::JR:
                    begin
                        ctrl.jr = 1'b1;
                        ctrl.delayEarly = 1'b1;
                    end
                    mipsDecodePkg::JALR:
                    begin
                        ctrl.jr = 1'b1;
                        ctrl.delayEarly = 1'b1;
                        ctrl.wbSel = mipsDecodePkg::PCPLUS4;
                    end
                    mipsDecodePkg::MFHI:
                    begin
                        ctrl.wbSel = mipsDecodePkg::HI;
                    end
                    mipsDecodePkg::MFLO:
                    begin
                        ctrl.wbSel = mipsDecodePkg::LO;
                    end
                    mipsDecodePkg::MTHI:
                    begin
                        ctrl.hiWrite = 1'b1;
                        ctrl.regWrite = mipsDecodePkg::NONE;
                    end
                    mipsDecodePkg::MTLO:
                    begin
                        ctrl.loWrite = 1'b1;
                        ctrl.regWrite = mipsDecodePkg::NONE;
                    end
                    // Multiply and divide fill both HI and LO
                    mipsDecodePkg::MULT, mipsDecodePkg::MULTU,
                    mipsDecodePkg::DIV, mipsDecodePkg::DIVU:
                    begin
                        ctrl.hiWrite = 1'b1;
                        ctrl.loWrite = 1'b1;
                        ctrl.regWrite = mipsDecodePkg::NONE;
                    end
                    default:
                    begin
                        ctrl.wbSel = mipsDecodePkg::ALU;
                    end
                endcase
            end

            mipsDecodePkg::ADDI, mipsDecodePkg::ADDIU, mipsDecodePkg::SLTI,
            mipsDecodePkg::SLTIU, mipsDecodePkg::ANDI, mipsDecodePkg::ORI,
            mipsDecodePkg::XORI, mipsDecodePkg::LUI:
            begin
                ctrl.regWrite = mipsDecodePkg::FULL;
            end

            // Unaligned loads merge one half into rt
            mipsDecodePkg::LWL:
            begin
                ctrl.regWrite = mipsDecodePkg::UPPER;
                ctrl.memRead = 1'b1;
                ctrl.wbSel = mipsDecodePkg::MEM;
            end
            mipsDecodePkg::LWR:
            begin
                ctrl.regWrite = mipsDecodePkg::LOWER;
                ctrl.memRead = 1'b1;
                ctrl.wbSel = mipsDecodePkg::MEM;
            end

            mipsDecodePkg::LB, mipsDecodePkg::LH, mipsDecodePkg::LW,
            mipsDecodePkg::LBU, mipsDecodePkg::LHU:
            begin
                ctrl.regWrite = mipsDecodePkg::FULL;
                ctrl.memRead = 1'b1;
                ctrl.wbSel = mipsDecodePkg::MEM;
            end

            mipsDecodePkg::SB, mipsDecodePkg::SH, mipsDecodePkg::SW:
            begin
                ctrl.memWrite = 1'b1;
            end

            mipsDecodePkg::J:
            begin
                ctrl.jump = 1'b1;
                ctrl.delayEarly = 1'b1;
            end
            mipsDecodePkg::JAL:
            begin
                ctrl.jump = 1'b1;
                ctrl.delayEarly = 1'b1;
                ctrl.regWrite = mipsDecodePkg::FULL;
                ctrl.wbSel = mipsDecodePkg::PCPLUS4;
                regDst = mipsDecodePkg::RA;
            end

            mipsDecodePkg::BEQ, mipsDecodePkg::BNE, mipsDecodePkg::BLEZ, mipsDecodePkg::BGTZ:
            begin
                ctrl.delayEarly = 1'b1;
            end
            mipsDecodePkg::REGIMM:
            begin
                ctrl.delayEarly = 1'b1;
                // BLTZAL and BGEZAL also link
                if (rt == mipsDecodePkg::bltzalRt || rt == mipsDecodePkg::bgezalRt)
                begin
                    ctrl.regWrite = mipsDecodePkg::FULL;
                    ctrl.wbSel = mipsDecodePkg::PCPLUS4;
                    regDst = mipsDecodePkg::RA;
                end
            end

            default:
            begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
    input  logic clk,
    input  logic rstN,
    input  logic instrValid,
    input  logic [mipsDecodePkg::dataWidth-1:0] instr,
    input  logic [mipsDecodePkg::dataWidth-1:0] pcPlus4,
    input  logic stall,
    input  mipsDecodePkg::wbReq_t wb,
    input  logic [mipsDecodePkg::dataWidth-1:0] hi,
    input  logic [mipsDecodePkg::dataWidth-1:0] lo,
    output mipsDecodePkg::idEx_t idEx
);

    mipsDecodePkg::opcode_t opcode;
    mipsDecodePkg::funct_t funct;
    logic [mipsDecodePkg::regAddrWidth-1:0] rs;
    logic [mipsDecodePkg::regAddrWidth-1:0] rt;
    logic [mipsDecodePkg::regAddrWidth-1:0] rd;
    logic [4:0] shamt;
    logic [mipsDecodePkg::halfWidth-1:0] imm16;

    mipsDecodePkg::ctrl_t ctrl;
    mipsDecodePkg::regDst_t regDst;
    logic [mipsDecodePkg::dataWidth-1:0] rsData;
    logic [mipsDecodePkg::dataWidth-1:0] rtData;
    logic [mipsDecodePkg::dataWidth-1:0] immExt;
    logic [mipsDecodePkg::regAddrWidth-1:0] destReg;
    mipsDecodePkg::idEx_t nextBundle;
    mipsDecodePkg::idEx_t bundleQ;
    mipsDecodePkg::ctrl_t ctrlQ;
    logic validQ;
    logic accept;

    // Instruction fields
    assign opcode = mipsDecodePkg::opcode_t'(instr[31:26]);
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign shamt = instr[10:6];
    assign funct = mipsDecodePkg::funct_t'(instr[5:0]);
    assign imm16 = instr[15:0];

    controlUnit ctrlDecoder (
        .opcode(opcode),
        .funct(funct),
        .rt(rt),
        .ctrl(ctrl),
        .regDst(regDst)
    );

    registerFile regFile (
        .clk(clk),
        .rstN(rstN),
        .rsAddr(rs),
        .rtAddr(rt),
        .rsData(rsData),
        .rtData(rtData),
        .wb(wb)
    );

    // Logical immediates zero-extend, LUI moves to the upper half
    always_comb
    begin
        case (opcode)
            mipsDecodePkg::ANDI, mipsDecodePkg::ORI, mipsDecodePkg::XORI:
                immExt = {{mipsDecodePkg::halfWidth{1'b0}}, imm16};
            mipsDecodePkg::LUI:
                immExt = {imm16, {mipsDecodePkg::halfWidth{1'b0}}};
            default:
                immExt = {{mipsDecodePkg::halfWidth{imm16[mipsDecodePkg::halfWidth-1]}}, imm16};
        endcase
    end

    always_comb
    begin
        case (regDst)
            mipsDecodePkg::RD: destReg = rd;
            mipsDecodePkg::RA: destReg = mipsDecodePkg::raReg;
            default: destReg = rt;
        endcase
    end

    always_comb
    begin
        nextBundle = '0;
        nextBundle.valid = 1'b1;
        nextBundle.ctrl = ctrl;
        nextBundle.rsData = rsData;
        nextBundle.rtData = rtData;
        nextBundle.imm = immExt;
        nextBundle.shamt = shamt;
        nextBundle.funct = funct;
        nextBundle.destReg = destReg;
        nextBundle.pcPlus4 = pcPlus4;
        nextBundle.hi = hi;
        nextBundle.lo = lo;
    end

    assign accept = instrValid && !stall;

    // Valid and control bits clear on reset and hold under stall
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            validQ <= 1'b0;
            ctrlQ <= '0;
        end
        else if (accept)
        begin
            validQ <= 1'b1;
            ctrlQ <= ctrl;
        end
        else if (!stall)
        begin
            validQ <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            bundleQ <= nextBundle;
        end
    end

    always_comb
    begin
        idEx = bundleQ;
        idEx.valid = validQ;
        idEx.ctrl = ctrlQ;
    end

    validLowInReset: assert property (@(posedge clk) !rstN |-> !idEx.valid)
        else $error("decodeStage: idEx.valid high during reset");

    stallHoldsBundle: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> $stable(idEx))
        else $error("decodeStage: idEx changed while stalled");

endmodule

// ==== hdl/decodeTop.sv ====
`timescale 1ns/1ps

module decodeTop (
    input  logic clk,
    input  logic rstN,
    input  logic instrValid,
    input  logic [mipsDecodePkg::dataWidth-1:0] instr,
    input  logic [mipsDecodePkg::dataWidth-1:0] pcPlus4,
    input  logic stall,
    input  mipsDecodePkg::wbReq_t wb,
    input  mipsDecodePkg::hiLoReq_t hiLoWb,
    output mipsDecodePkg::idEx_t idEx
);

    logic [mipsDecodePkg::dataWidth-1:0] hi;
    logic [mipsDecodePkg::dataWidth-1:0] lo;

    // HI/LO sit beside the stage and take writeback from outside
    hiLoRegs hiLo (
        .clk(clk),
        .rstN(rstN),
        .req(hiLoWb),
        .hi(hi),
        .lo(lo)
    );

    decodeStage stage (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .instr(instr),
        .pcPlus4(pcPlus4),
        .stall(stall),
        .wb(wb),
        .hi(hi),
        .lo(lo),
        .idEx(idEx)
    );

endmodule

// ==== hdl/hiLoRegs.sv ====
`timescale 1ns/1ps

module hiLoRegs (
    input  logic clk,
    input  logic rstN,
    input  mipsDecodePkg::hiLoReq_t req,
    output logic [mipsDecodePkg::dataWidth-1:0] hi,
    output logic [mipsDecodePkg::dataWidth-1:0] lo
);

    logic [mipsDecodePkg::dataWidth-1:0] hiQ;
    logic [mipsDecodePkg::dataWidth-1:0] loQ;

    // HI side, written by MTHI and multiply/divide results
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            hiQ <= '0;
        end
        else if (req.hiWrite)
        begin
            hiQ <= req.hi;
        end
    end

    // LO side, same sources with its own strobe
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            loQ <= '0;
        end
        else if (req.loWrite)
        begin
            loQ <= req.lo;
        end
    end

    // Pending write wins so MFHI/MFLO in the same cycle see it
    assign hi = req.hiWrite ? req.hi : hiQ;
    assign lo = req.loWrite ? req.lo : loQ;

endmodule

// ==== hdl/mipsDecodePkg.sv ====
package mipsDecodePkg;

    // Datapath sizing
    localparam int dataWidth = 32;
    localparam int halfWidth = dataWidth / 2;
    localparam int regCount = 32;
    localparam int regAddrWidth = $clog2(regCount);

    // Link register for JAL and the linking branches
    localparam logic [regAddrWidth-1:0] raReg = 5'd31;

    // REGIMM rt codes that write the link register
    localparam logic [regAddrWidth-1:0] bltzalRt = 5'h10;
    localparam logic [regAddrWidth-1:0] bgezalRt = 5'h11;

    typedef enum logic [5:0] {
        RTYPE = 6'h00, REGIMM = 6'h01, J = 6'h02, JAL = 6'h03,
        BEQ = 6'h04, BNE = 6'h05, BLEZ = 6'h06, BGTZ = 6'h07,
        ADDI = 6'h08, ADDIU = 6'h09, SLTI = 6'h0a, SLTIU = 6'h0b,
        ANDI = 6'h0c, ORI = 6'h0d, XORI = 6'h0e, LUI = 6'h0f,
        LB = 6'h20, LH = 6'h21, LWL = 6'h22, LW = 6'h23,
        LBU = 6'h24, LHU = 6'h25, LWR = 6'h26,
        SB = 6'h28, SH = 6'h29, SW = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        SLL = 6'h00, JR = 6'h08, JALR = 6'h09,
        MFHI = 6'h10, MTHI = 6'h11, MFLO = 6'h12, MTLO = 6'h13,
        MULT = 6'h18, MULTU = 6'h19, DIV = 6'h1a, DIVU = 6'h1b,
        ADDU = 6'h21, SUBU = 6'h23, AND = 6'h24, OR = 6'h25, SLT = 6'h2a
    } funct_t;

    typedef enum logic [1:0] {RT = 2'd0, RD = 2'd1, RA = 2'd2} regDst_t;

    typedef enum logic [2:0] {ALU = 3'd0, MEM = 3'd1, PCPLUS4 = 3'd2, HI = 3'd3, LO = 3'd4} wbSel_t;

    // LOWER and UPPER name the half of the word that gets written
    typedef enum logic [1:0] {NONE = 2'd0, LOWER = 2'd1, UPPER = 2'd2, FULL = 2'd3} regWrite_t;

    typedef struct packed {
        logic jr;
        logic jump;
        regWrite_t regWrite;
        logic memRead;
        logic memWrite;
        wbSel_t wbSel;
        logic hiWrite;
        logic loWrite;
        logic delayEarly;
    } ctrl_t;

    typedef struct packed {
        regWrite_t regWrite;
        logic [regAddrWidth-1:0] destReg;
        logic [dataWidth-1:0] data;
    } wbReq_t;

    typedef struct packed {
        logic hiWrite;
        logic loWrite;
        logic [dataWidth-1:0] hi;
        logic [dataWidth-1:0] lo;
    } hiLoReq_t;

    typedef struct packed {
        logic valid;
        ctrl_t ctrl;
        logic [dataWidth-1:0] rsData;
        logic [dataWidth-1:0] rtData;
        logic [dataWidth-1:0] imm;
        logic [4:0] shamt;
        funct_t funct;
        logic [regAddrWidth-1:0] destReg;
        logic [dataWidth-1:0] pcPlus4;
        logic [dataWidth-1:0] hi;
        logic [dataWidth-1:0] lo;
    } idEx_t;

endpackage

// ==== hdl/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
    input  logic clk,
    input  logic rstN,
    input  logic [mipsDecodePkg::regAddrWidth-1:0] rsAddr,
    input  logic [mipsDecodePkg::regAddrWidth-1:0] rtAddr,
    output logic [mipsDecodePkg::dataWidth-1:0] rsData,
    output logic [mipsDecodePkg::dataWidth-1:0] rtData,
    input  mipsDecodePkg::wbReq_t wb
);

    logic [mipsDecodePkg::dataWidth-1:0] regs [mipsDecodePkg::regCount];
    logic [mipsDecodePkg::dataWidth-1:0] oldWord;
    logic [mipsDecodePkg::dataWidth-1:0] mergedWord;
    logic writeEn;

    // Register 0 is hardwired, so its writes go nowhere
    assign writeEn = (wb.regWrite != mipsDecodePkg::NONE) && (wb.destReg != '0);

    // Half writes keep the other half of the current word
    always_comb
    begin
        oldWord = regs[wb.destReg];
        case (wb.regWrite)
            mipsDecodePkg::UPPER:
                mergedWord = {wb.data[mipsDecodePkg::dataWidth-1:mipsDecodePkg::halfWidth],
                              oldWord[mipsDecodePkg::halfWidth-1:0]};
            mipsDecodePkg::LOWER:
                mergedWord = {oldWord[mipsDecodePkg::dataWidth-1:mipsDecodePkg::halfWidth],
                              wb.data[mipsDecodePkg::halfWidth-1:0]};
            default:
                mergedWord = wb.data;
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < mipsDecodePkg::regCount; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEn)
        begin
            regs[wb.destReg] <= mergedWord;
        end
    end

    // Write-through so decode sees this cycle's writeback
    assign rsData = (rsAddr == '0) ? '0 :
                    (writeEn && rsAddr == wb.destReg) ? mergedWord : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 :
                    (writeEn && rtAddr == wb.destReg) ? mergedWord : regs[rtAddr];

endmodule

// ==== project.f ====
hdl/mipsDecodePkg.sv
hdl/controlUnit.sv
hdl/registerFile.sv
hdl/hiLoRegs.sv
hdl/decodeStage.sv
hdl/decodeTop.sv
tb/decodeTb.sv

// ==== tb/decodeTb.sv ====
`timescale 1ns/1ps

module decodeTb;

    logic clk;
    logic rstN;
    logic instrValid;
    logic [31:0] instr;
    logic [31:0] pcPlus4;
    logic stall;
    mipsDecodePkg::wbReq_t wb;
    mipsDecodePkg::hiLoReq_t hiLoWb;
    mipsDecodePkg::idEx_t idEx;

    integer seed;
    int cycleCount = 0;
    logic stallAtEdge;
    logic [31:0] pcCount;
    logic [31:0] shadowRegs [32];
    logic [31:0] shadowHi;
    logic [31:0] shadowLo;
    // Expected bundles with the cycle in which each must appear
    mipsDecodePkg::idEx_t expQ[$];
    int dueQ[$];
    string nameQ[$];
    mipsDecodePkg::idEx_t expHead;
    mipsDecodePkg::idEx_t lastExp;
    string headName;
    int dueCycle;

    decodeTop UUT (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .instr(instr),
        .pcPlus4(pcPlus4),
        .stall(stall),
        .wb(wb),
        .hiLoWb(hiLoWb),
        .idEx(idEx)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Stall as the DUT saw it on the last edge
    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        stallAtEdge <= stall;
    end

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic mipsDecodePkg::ctrl_t refCtrl(input logic [5:0] op, input logic [5:0] fn,
                                                     input logic [4:0] rt);
        mipsDecodePkg::ctrl_t c;
        logic mulDiv;
        c = '0;
        mulDiv = (fn == mipsDecodePkg::MULT) || (fn == mipsDecodePkg::MULTU) ||
                 (fn == mipsDecodePkg::DIV) || (fn == mipsDecodePkg::DIVU);
        case (op)
            mipsDecodePkg::RTYPE:
            begin
                c.regWrite = mipsDecodePkg::FULL;
                c.jr = (fn == mipsDecodePkg::JR) || (fn == mipsDecodePkg::JALR);
                c.delayEarly = c.jr;
                if (fn == mipsDecodePkg::JALR)
                    c.wbSel = mipsDecodePkg::PCPLUS4;
                if (fn == mipsDecodePkg::MFHI)
                    c.wbSel = mipsDecodePkg::HI;
                if (fn == mipsDecodePkg::MFLO)
                    c.wbSel = mipsDecodePkg::LO;
                c.hiWrite = (fn == mipsDecodePkg::MTHI) || mulDiv;
                c.loWrite = (fn == mipsDecodePkg::MTLO) || mulDiv;
                if (c.hiWrite || c.loWrite)
                    c.regWrite = mipsDecodePkg::NONE;
            end
            mipsDecodePkg::ADDI, mipsDecodePkg::ADDIU, mipsDecodePkg::SLTI, mipsDecodePkg::SLTIU,
            mipsDecodePkg::ANDI, mipsDecodePkg::ORI, mipsDecodePkg::XORI, mipsDecodePkg::LUI:
                c.regWrite = mipsDecodePkg::FULL;
            mipsDecodePkg::LB, mipsDecodePkg::LH, mipsDecodePkg::LW, mipsDecodePkg::LBU,
            mipsDecodePkg::LHU, mipsDecodePkg::LWL, mipsDecodePkg::LWR:
            begin
                c.memRead = 1'b1;
                c.wbSel = mipsDecodePkg::MEM;
                if (op == mipsDecodePkg::LWL)
                    c.regWrite = mipsDecodePkg::UPPER;
                else if (op == mipsDecodePkg::LWR)
                    c.regWrite = mipsDecodePkg::LOWER;
                else
                    c.regWrite = mipsDecodePkg::FULL;
            end
            mipsDecodePkg::SB, mipsDecodePkg::SH, mipsDecodePkg::SW:
                c.memWrite = 1'b1;
            mipsDecodePkg::J, mipsDecodePkg::JAL:
            begin
                c.jump = 1'b1;
                c.delayEarly = 1'b1;
            end
            mipsDecodePkg::BEQ, mipsDecodePkg::BNE, mipsDecodePkg::BLEZ, mipsDecodePkg::BGTZ,
            mipsDecodePkg::REGIMM:
                c.delayEarly = 1'b1;
            default: ;
        endcase
        // Linking forms write the return address
        if (op == mipsDecodePkg::JAL ||
            (op == mipsDecodePkg::REGIMM && (rt == 5'd16 || rt == 5'd17)))
        begin
            c.regWrite = mipsDecodePkg::FULL;
            c.wbSel = mipsDecodePkg::PCPLUS4;
        end
        return c;
    endfunction

    function automatic logic [31:0] refImm(input logic [5:0] op, input logic [15:0] imm16);
        if (op == mipsDecodePkg::ANDI || op == mipsDecodePkg::ORI || op == mipsDecodePkg::XORI)
            return {16'h0000, imm16};
        if (op == mipsDecodePkg::LUI)
            return {imm16, 16'h0000};
        return {{16{imm16[15]}}, imm16};
    endfunction

    function automatic logic [4:0] refDest(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rd);
        if (op == mipsDecodePkg::RTYPE)
            return rd;
        if (op == mipsDecodePkg::JAL ||
            (op == mipsDecodePkg::REGIMM && (rt == 5'd16 || rt == 5'd17)))
            return mipsDecodePkg::raReg;
        return rt;
    endfunction

    function automatic mipsDecodePkg::idEx_t refBundle(input logic [31:0] word,
                                                       input logic [31:0] pc);
        mipsDecodePkg::idEx_t b;
        b = '0;
        b.valid = 1'b1;
        b.ctrl = refCtrl(word[31:26], word[5:0], word[20:16]);
        b.rsData = shadowRegs[word[25:21]];
        b.rtData = shadowRegs[word[20:16]];
        b.imm = refImm(word[31:26], word[15:0]);
        b.shamt = word[10:6];
        b.funct = mipsDecodePkg::funct_t'(word[5:0]);
        b.destReg = refDest(word[31:26], word[20:16], word[15:11]);
        b.pcPlus4 = pc;
        b.hi = shadowHi;
        b.lo = shadowLo;
        return b;
    endfunction

    // Shadow state already holds this cycle's writes, matching write-through reads
    task automatic applyWriteback(input mipsDecodePkg::wbReq_t w, input mipsDecodePkg::hiLoReq_t h);
        if (w.destReg != 5'd0)
        begin
            case (w.regWrite)
                mipsDecodePkg::FULL: shadowRegs[w.destReg] = w.data;
                mipsDecodePkg::UPPER: shadowRegs[w.destReg][31:16] = w.data[31:16];
                mipsDecodePkg::LOWER: shadowRegs[w.destReg][15:0] = w.data[15:0];
                default: ;
            endcase
        end
        if (h.hiWrite)
            shadowHi = h.hi;
        if (h.loWrite)
            shadowLo = h.lo;
    endtask

    task automatic driveCycle(input logic strobe, input logic [31:0] word, input logic hold,
                              input mipsDecodePkg::wbReq_t w, input mipsDecodePkg::hiLoReq_t h,
                              input string name);
        @(posedge clk);
        #1;
        instrValid = strobe;
        instr = word;
        pcPlus4 = pcCount;
        stall = hold;
        wb = w;
        hiLoWb = h;
        applyWriteback(w, h);
        if (strobe && !hold)
        begin
            lastExp = refBundle(word, pcCount);
            expQ.push_back(lastExp);
            dueQ.push_back(cycleCount + 1);
            nameQ.push_back(name);
            pcCount = pcCount + 4;
        end
    endtask

    // Idle the inputs, then let the compare process empty its queue
    task automatic waitForDrain(input string what);
        int count;
        count = 0;
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        wb = '0;
        hiLoWb = '0;
        while (dueQ.size() > 0 && count < 10)
        begin
            @(negedge clk);
            #1;
            count++;
        end
        if (dueQ.size() > 0)
            stopRun($sformatf("Timeout while waiting for idEx.valid after %s", what));
    endtask

    // Every fresh valid bundle must match the oldest expected one
    always @(negedge clk)
    begin
        if (rstN && idEx.valid === 1'b1 && !stallAtEdge)
        begin
            if (dueQ.size() == 0 || dueQ[0] > cycleCount)
                stopRun("idEx.valid went high although no instruction was accepted");
            else
            begin
                expHead = expQ.pop_front();
                headName = nameQ.pop_front();
                dueCycle = dueQ.pop_front();
                assert (dueCycle == cycleCount)
                else stopRun($sformatf("FAILED %s latency expected cycle %0d actual cycle %0d",
                                       headName, dueCycle, cycleCount));
                assert (idEx === expHead)
                else stopRun($sformatf("FAILED %s expected %h actual %h",
                                       headName, expHead, idEx));
            end
        end
    end

    initial
    begin : stimulus
        mipsDecodePkg::wbReq_t w;
        mipsDecodePkg::hiLoReq_t h;
        mipsDecodePkg::opcode_t op;
        mipsDecodePkg::funct_t fn;
        logic [31:0] word;
        seed = 79986;
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        pcPlus4 = '0;
        stall = 1'b0;
        wb = '0;
        hiLoWb = '0;
        pcCount = 32'h0040_0004;
        shadowHi = '0;
        shadowLo = '0;
        for (int r = 0; r < 32; r++)
            shadowRegs[r] = '0;
        w = '0;
        h = '0;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        assert (!idEx.valid && idEx.ctrl == '0)
        else stopRun("idEx.valid or control bits were set coming out of reset");

        // Every opcode, every funct, random remaining fields
        op = op.first();
        do
        begin
            if (op == mipsDecodePkg::RTYPE)
            begin
                fn = fn.first();
                do
                begin
                    word = $random(seed);
                    word[31:26] = op;
                    word[5:0] = fn;
                    driveCycle(1'b1, word, 1'b0, w, h, "control decode");
                    fn = fn.next();
                end
                while (fn != fn.first());
            end
            else
            begin
                // REGIMM sweeps rt 15..18 around the linking codes
                for (int k = 0; k < ((op == mipsDecodePkg::REGIMM) ? 4 : 1); k++)
                begin
                    word = $random(seed);
                    word[31:26] = op;
                    if (op == mipsDecodePkg::REGIMM)
                        word[20:16] = 5'd15 + 5'(k);
                    driveCycle(1'b1, word, 1'b0, w, h, "control decode");
                end
            end
            op = op.next();
        end
        while (op != op.first());

        // Extension corners and the three destination rules
        driveCycle(1'b1, {mipsDecodePkg::ANDI, 5'd3, 5'd4, 16'h8000}, 1'b0, w, h, "zero extend");
        driveCycle(1'b1, {mipsDecodePkg::XORI, 5'd5, 5'd6, 16'hc3a5}, 1'b0, w, h, "zero extend");
        driveCycle(1'b1, {mipsDecodePkg::ADDI, 5'd7, 5'd8, 16'h8001}, 1'b0, w, h, "sign extend");
        driveCycle(1'b1, {mipsDecodePkg::LW, 5'd9, 5'd10, 16'h7fff}, 1'b0, w, h, "sign extend");
        driveCycle(1'b1, {mipsDecodePkg::LUI, 5'd0, 5'd11, 16'h1234}, 1'b0, w, h, "lui extend");
        driveCycle(1'b1, {mipsDecodePkg::RTYPE, 5'd1, 5'd2, 5'd9, 5'd4, mipsDecodePkg::SUBU},
                   1'b0, w, h, "rd destination");
        driveCycle(1'b1, {mipsDecodePkg::JAL, 26'h3ff_ffff}, 1'b0, w, h, "ra destination");
        driveCycle(1'b1, {mipsDecodePkg::REGIMM, 5'd6, 5'd17, 16'h0010}, 1'b0, w, h,
                   "ra destination");
        waitForDrain("decode sweep");

        // Random writebacks, most with a same-cycle read of the written register
        for (int i = 0; i < 40; i++)
        begin
            w.regWrite = mipsDecodePkg::regWrite_t'(1 + $unsigned($random(seed)) % 3);
            w.destReg = 5'(1 + $unsigned($random(seed)) % 31);
            w.data = $random(seed);
            word = {mipsDecodePkg::RTYPE, 5'(i), w.destReg, 5'd2, 5'd0, mipsDecodePkg::ADDU};
            driveCycle(i % 4 != 3, word, 1'b0, w, h, "register writeback");
        end
        w = '0;
        for (int r = 0; r < 31; r++)
        begin
            word = {mipsDecodePkg::RTYPE, 5'(r), 5'(r + 1), 5'd3, 5'd0, mipsDecodePkg::OR};
            driveCycle(1'b1, word, 1'b0, w, h, "register readback");
        end

        // Register 0 drops writes
        w.regWrite = mipsDecodePkg::FULL;
        w.destReg = 5'd0;
        w.data = 32'hdead_beef;
        word = {mipsDecodePkg::RTYPE, 5'd0, 5'd0, 5'd7, 5'd0, mipsDecodePkg::ADDU};
        driveCycle(1'b1, word, 1'b0, w, h, "register zero");
        w.regWrite = mipsDecodePkg::UPPER;
        driveCycle(1'b1, {mipsDecodePkg::ADDIU, 5'd0, 5'd5, 16'h0001}, 1'b0, w, h, "register zero");
        w = '0;
        driveCycle(1'b1, {mipsDecodePkg::ORI, 5'd0, 5'd0, 16'h0001}, 1'b0, w, h, "register zero");

        // HI and LO strobes, alone, together and ahead of a later decode
        h.hiWrite = 1'b1;
        h.hi = $random(seed);
        h.lo = $random(seed);
        driveCycle(1'b1, {mipsDecodePkg::RTYPE, 20'd0, mipsDecodePkg::MFHI}, 1'b0, w, h,
                   "hi lo write");
        h.hiWrite = 1'b0;
        h.loWrite = 1'b1;
        h.lo = $random(seed);
        driveCycle(1'b1, {mipsDecodePkg::RTYPE, 20'd0, mipsDecodePkg::MFLO}, 1'b0, w, h,
                   "hi lo write");
        h.hiWrite = 1'b1;
        h.hi = $random(seed);
        h.lo = $random(seed);
        driveCycle(1'b0, 32'h0, 1'b0, w, h, "hi lo write");
        h = '0;
        driveCycle(1'b1, {mipsDecodePkg::RTYPE, 20'd0, mipsDecodePkg::MULT}, 1'b0, w, h,
                   "hi lo write");
        waitForDrain("hi lo writes");

        // Stall holds the bundle and ignores strobes
        driveCycle(1'b1, {mipsDecodePkg::LW, 5'd4, 5'd8, 16'h0040}, 1'b0, w, h, "stall");
        for (int i = 0; i < 5; i++)
        begin
            driveCycle(1'b1, $random(seed), 1'b1, w, h, "stall");
            @(negedge clk);
            #1;
            assert (idEx === lastExp)
            else stopRun($sformatf("FAILED stall hold expected %h actual %h", lastExp, idEx));
        end
        driveCycle(1'b1, {mipsDecodePkg::ORI, 5'd8, 5'd9, 16'h00f0}, 1'b0, w, h, "after stall");
        waitForDrain("stall release");

        // Reset while a stalled bundle is valid
        driveCycle(1'b1, {mipsDecodePkg::SW, 5'd2, 5'd3, 16'hfff8}, 1'b0, w, h, "reset");
        driveCycle(1'b0, 32'h0, 1'b1, w, h, "reset");
        @(posedge clk);
        #1;
        assert (idEx.valid)
        else stopRun("idEx.valid dropped while stall was held");
        rstN = 1'b0;
        #1;
        assert (!idEx.valid && idEx.ctrl == '0)
        else stopRun("idEx.valid or control bits stayed set after reset was asserted");

        if (dueQ.size() != 0)
            stopRun("Expected bundles were left unchecked at the end of the run");
        else
        begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule
